/* project.f */
axil_pkg.sv
pref_pkg.sv
simp_if.sv
axil_simp_bridge.sv
simp_addr_router.sv
pref_cfg_regs.sv
pref_event_counters.sv
pref_ctrl_top.sv
tb_pref_ctrl_asserts.sv
tb_pref_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pref_ctrl
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ns -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_pref_ctrl.sv */
// Testbench for the prefetcher configuration port with random AXI-lite traffic and a model.
`timescale 1ns/1ns

module tb_pref_ctrl;

	localparam int CLK_PERIOD  = 4;
	localparam int CNT_W       = 4;
	localparam int N_TRANS     = 400;
	localparam int WATCHDOG_NS = N_TRANS * 40 * CLK_PERIOD;
	localparam logic [CNT_W-1:0] SAT = '1;

	logic                        clk;
	logic                        rst;
	logic                        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
	logic [axil_pkg::ADDR_W-1:0] awaddr_i, araddr_i;
	logic [axil_pkg::DATA_W-1:0] wdata_i;
	logic [axil_pkg::STRB_W-1:0] wstrb_i;
	logic [2:0]                  awprot_i, arprot_i;
	logic                        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
	logic [1:0]                  bresp_o, rresp_o;
	logic [axil_pkg::DATA_W-1:0] rdata_o;
	logic                        hit_i, miss_i;
	logic                        pref_enable_o;
	logic [1:0]                  pref_mode_o;
	logic [3:0]                  pref_degree_o;
	logic [31:0]                 pref_base_o, pref_stride_o;

	// Model state. The config words are indexed by address bits 3:2.
	logic [31:0]      cfg_m [4];
	logic [CNT_W-1:0] hit_m, miss_m;
	logic [31:0]      rng_q;
	int               error_cnt;

	pref_ctrl_top #(.CNT_W (CNT_W)) i_dut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random numbers and model helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_word();
		rng_q = xorshift32(rng_q);
		return rng_q;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		return next_word() % n;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] r;
		r = old_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				r[8*b +: 8] = new_w[8*b +: 8];
		end
		return r;
	endfunction

	function automatic logic [31:0] expect_read(input logic [4:0] a);
		logic [31:0] r;
		r = '0;
		case (a)
			pref_pkg::REG_CTRL:    r = cfg_m[0] & pref_pkg::CTRL_MASK;
			pref_pkg::REG_BASE:    r = cfg_m[1];
			pref_pkg::REG_STRIDE:  r = cfg_m[2];
			pref_pkg::REG_SCRATCH: r = cfg_m[3];
			pref_pkg::REG_HITS:    r[CNT_W-1:0] = hit_m;
			pref_pkg::REG_MISSES:  r[CNT_W-1:0] = miss_m;
			pref_pkg::REG_STATUS:  r[1:0] = {miss_m == SAT, hit_m == SAT};
			default:               r = '0;  // CLEAR reads as zero.
		endcase
		return r;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		error_cnt++;
	endtask

	task automatic model_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] s);
		if (!a[4]) begin
			cfg_m[a[3:2]] = merge_bytes(cfg_m[a[3:2]], d, s);
		end else if (a == pref_pkg::REG_CLEAR) begin
			if (d[0])
				hit_m = '0;
			if (d[1])
				miss_m = '0;
		end
	endtask

	task automatic check_outputs();
		if (pref_enable_o !== cfg_m[0][0])
			report_error($sformatf("pref_enable_o is %0b, expected %0b", pref_enable_o, cfg_m[0][0]));
		if (pref_mode_o !== cfg_m[0][2:1])
			report_error($sformatf("pref_mode_o is %0d, expected %0d", pref_mode_o, cfg_m[0][2:1]));
		if (pref_degree_o !== cfg_m[0][6:3])
			report_error($sformatf("pref_degree_o is %0d, expected %0d", pref_degree_o,
				cfg_m[0][6:3]));
		if (pref_base_o !== cfg_m[1])
			report_error($sformatf("pref_base_o is %h, expected %h", pref_base_o, cfg_m[1]));
		if (pref_stride_o !== cfg_m[2])
			report_error($sformatf("pref_stride_o is %h, expected %h", pref_stride_o, cfg_m[2]));
	endtask

	// Address and data channels stall while a response waits.
	task automatic check_blocked();
		if (arready_o || awready_o || wready_o)
			report_error($sformatf("ready high while a response waits, ar %0b aw %0b w %0b",
				arready_o, awready_o, wready_o));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI-lite drivers. Each starts and ends on a falling edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic axil_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] s);
		int unsigned aw_dly, w_dly, b_dly;
		aw_dly = pick(4);  // AW and W are skewed against each other.
		w_dly  = pick(4);
		b_dly  = pick(4);
		fork
			begin
				repeat (aw_dly) @(negedge clk);
				awvalid_i = 1'b1;
				awaddr_i  = a;
				#1;
				while (!awready_o) begin
					@(negedge clk);
					#1;
				end
				@(negedge clk);
				awvalid_i = 1'b0;
			end
			begin
				repeat (w_dly) @(negedge clk);
				wvalid_i = 1'b1;
				wdata_i  = d;
				wstrb_i  = s;
				#1;
				while (!wready_o) begin
					@(negedge clk);
					#1;
				end
				@(negedge clk);
				wvalid_i = 1'b0;
			end
		join
		#1;
		while (!bvalid_o) begin
			@(negedge clk);
			#1;
		end
		check_blocked();
		repeat (b_dly) begin
			@(negedge clk);
			#1;
			if (!bvalid_o)
				report_error("bvalid dropped before bready");
			check_blocked();
		end
		@(negedge clk);
		bready_i = 1'b1;
		#1;
		if (!bvalid_o)
			report_error("bvalid low when bready was raised");
		if (bresp_o !== axil_pkg::RESP_OKAY)
			report_error($sformatf("bresp is %0d, expected OKAY", bresp_o));
		@(negedge clk);
		bready_i = 1'b0;
	endtask

	task automatic axil_read(input logic [4:0] a, output logic [31:0] d);
		int unsigned r_dly;
		r_dly     = pick(4);
		arvalid_i = 1'b1;
		araddr_i  = a;
		#1;
		while (!arready_o) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid_i = 1'b0;
		#1;
		while (!rvalid_o) begin
			@(negedge clk);
			#1;
		end
		check_blocked();
		repeat (r_dly) begin
			@(negedge clk);
			#1;
			if (!rvalid_o)
				report_error("rvalid dropped before rready");
			check_blocked();
		end
		@(negedge clk);
		rready_i = 1'b1;
		#1;
		if (!rvalid_o)
			report_error("rvalid low when rready was raised");
		if (rresp_o !== axil_pkg::RESP_OKAY)
			report_error($sformatf("rresp is %0d, expected OKAY", rresp_o));
		d = rdata_o;
		@(negedge clk);
		rready_i = 1'b0;
	endtask

	task automatic read_and_check(input logic [4:0] a);
		logic [31:0] got;
		logic [31:0] exp;
		axil_read(a, got);
		exp = expect_read(a);
		if (got !== exp)
			report_error($sformatf("read of %h returned %h, expected %h", a, got, exp));
	endtask

	// Idle cycles with random events. The model counts what is driven.
	task automatic event_gap();
		logic [31:0] w;
		int unsigned n;
		n = pick(8);
		repeat (n) begin
			w      = next_word();
			hit_i  = w[0];
			miss_i = w[1];
			if (w[0] && hit_m != SAT)
				hit_m = hit_m + 1'b1;
			if (w[1] && miss_m != SAT)
				miss_m = miss_m + 1'b1;
			@(negedge clk);
		end
		hit_i  = 1'b0;
		miss_i = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [31:0] w;
		logic [31:0] data;
		logic [4:0]  addr;
		logic [3:0]  strb;
		rst       = 1'b1;
		awvalid_i = 1'b0;
		awaddr_i  = '0;
		wvalid_i  = 1'b0;
		wdata_i   = '0;
		wstrb_i   = '0;
		bready_i  = 1'b0;
		arvalid_i = 1'b0;
		araddr_i  = '0;
		rready_i  = 1'b0;
		awprot_i  = '0;
		arprot_i  = '0;
		hit_i     = 1'b0;
		miss_i    = 1'b0;
		rng_q     = 32'd93;
		error_cnt = 0;
		hit_m     = '0;
		miss_m    = '0;
		for (int i = 0; i < 4; i++)
			cfg_m[i] = '0;

		repeat (4) @(negedge clk);
		rst = 1'b0;
		if (rvalid_o || bvalid_o || pref_enable_o)
			report_error("response or enable high after reset");
		check_outputs();

		for (int t = 0; t < N_TRANS; t++) begin
			event_gap();
			w        = next_word();
			addr     = {w[2:0], 2'b00};
			awprot_i = w[6:4];  // Protection bits are ignored by the DUT.
			arprot_i = w[9:7];
			if (w[3]) begin
				data = next_word();
				w    = next_word();
				strb = w[4] ? 4'hF : w[3:0];
				axil_write(addr, data, strb);
				model_write(addr, data, strb);
				check_outputs();
				if (addr[4])
					read_and_check(addr);  // Counter writes other than CLEAR do nothing.
			end else begin
				read_and_check(addr);
			end
		end

		$display("Run finished with %0d errors", error_cnt);
		if (error_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the transactions did not finish in the allowed time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb_pref_ctrl_asserts.sv */
// Concurrent assertions on the AXI-lite and simp handshakes of the bridge.
`timescale 1ns/1ns

module tb_pref_ctrl_asserts (
	input logic                        clk,
	input logic                        rst,
	input logic                        arvalid_i,
	input logic                        arready_o,
	input logic                        rvalid_o,
	input logic                        bvalid_o,
	input logic                        simp_valid,
	input logic                        simp_done,
	input logic                        simp_wr,
	input logic                        simp_rd,
	input logic [axil_pkg::ADDR_W-1:0] simp_addr,
	input logic [axil_pkg::DATA_W-1:0] simp_wdata,
	input logic [axil_pkg::STRB_W-1:0] simp_be
);

	a_no_ar_during_resp: assert property (@(posedge clk) disable iff (rst)
		(rvalid_o || bvalid_o) |-> !arready_o)
		else $error("arready high while a response is pending");

	a_done_single: assert property (@(posedge clk) disable iff (rst)
		simp_done |=> !simp_done)
		else $error("simp done lasted more than one cycle");

	// The request must not move between valid and done.
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		(simp_valid && !simp_done) |=> (simp_valid && $stable(simp_addr) &&
		$stable(simp_wdata) && $stable(simp_be) && $stable(simp_wr) && $stable(simp_rd)))
		else $error("simp request changed while waiting for done");

	a_read_latency: assert property (@(posedge clk) disable iff (rst)
		(arvalid_i && arready_o) |-> ##3 $rose(rvalid_o))
		else $error("rvalid did not rise three cycles after the AR handshake");

endmodule

bind axil_simp_bridge tb_pref_ctrl_asserts i_asserts (
	.clk        (clk),
	.rst        (rst),
	.arvalid_i  (arvalid_i),
	.arready_o  (arready_o),
	.rvalid_o   (rvalid_o),
	.bvalid_o   (bvalid_o),
	.simp_valid (bus_o.valid),
	.simp_done  (bus_o.done),
	.simp_wr    (bus_o.wr),
	.simp_rd    (bus_o.rd),
	.simp_addr  (bus_o.addr),
	.simp_wdata (bus_o.wdata),
	.simp_be    (bus_o.be)
);

/* pref_ctrl_top.sv */
// Prefetcher configuration port top with the AXI-lite bridge, router and slaves.
`timescale 1ns/1ns

module pref_ctrl_top #(
	parameter int CNT_W = pref_pkg::CNT_W_DEF
) (
	input  logic                        clk,
	input  logic                        rst,

	input  logic                        awvalid_i,
	input  logic [axil_pkg::ADDR_W-1:0] awaddr_i,
	input  logic                        wvalid_i,
	input  logic [axil_pkg::DATA_W-1:0] wdata_i,
	input  logic [axil_pkg::STRB_W-1:0] wstrb_i,
	input  logic                        bready_i,
	input  logic                        arvalid_i,
	input  logic [axil_pkg::ADDR_W-1:0] araddr_i,
	input  logic                        rready_i,
	input  logic [2:0]                  awprot_i,
	input  logic [2:0]                  arprot_i,

	output logic                        awready_o,
	output logic                        wready_o,
	output logic                        bvalid_o,
	output logic [1:0]                  bresp_o,
	output logic                        arready_o,
	output logic                        rvalid_o,
	output logic [axil_pkg::DATA_W-1:0] rdata_o,
	output logic [1:0]                  rresp_o,

	input  logic                        hit_i,   // Prefetch hit event.
	input  logic                        miss_i,  // Prefetch miss event.
	output logic                        pref_enable_o,
	output logic [1:0]                  pref_mode_o,
	output logic [3:0]                  pref_degree_o,
	output logic [31:0]                 pref_base_o,
	output logic [31:0]                 pref_stride_o
);

	simp_if bus_up ();
	simp_if bus_regs ();
	simp_if bus_cnt ();

	axil_simp_bridge i_bridge (
		.clk       (clk),
		.rst       (rst),
		.awvalid_i (awvalid_i),
		.awaddr_i  (awaddr_i),
		.wvalid_i  (wvalid_i),
		.wdata_i   (wdata_i),
		.wstrb_i   (wstrb_i),
		.bready_i  (bready_i),
		.arvalid_i (arvalid_i),
		.araddr_i  (araddr_i),
		.rready_i  (rready_i),
		.awprot_i  (awprot_i),
		.arprot_i  (arprot_i),
		.awready_o (awready_o),
		.wready_o  (wready_o),
		.bvalid_o  (bvalid_o),
		.bresp_o   (bresp_o),
		.arready_o (arready_o),
		.rvalid_o  (rvalid_o),
		.rdata_o   (rdata_o),
		.rresp_o   (rresp_o),
		.bus_o     (bus_up)
	);

	simp_addr_router i_router (
		.bus_i  (bus_up),
		.regs_o (bus_regs),
		.cnt_o  (bus_cnt)
	);

	pref_cfg_regs i_regs (
		.clk           (clk),
		.rst           (rst),
		.bus_i         (bus_regs),
		.pref_enable_o (pref_enable_o),
		.pref_mode_o   (pref_mode_o),
		.pref_degree_o (pref_degree_o),
		.pref_base_o   (pref_base_o),
		.pref_stride_o (pref_stride_o)
	);

	pref_event_counters #(
		.CNT_W (CNT_W)
	) i_counters (
		.clk    (clk),
		.rst    (rst),
		.bus_i  (bus_cnt),
		.hit_i  (hit_i),
		.miss_i (miss_i)
	);

endmodule

/* pref_event_counters.sv */
// Saturating prefetch hit and miss counters with status and clear registers.
`timescale 1ns/1ns

module pref_event_counters #(
	parameter int CNT_W = pref_pkg::CNT_W_DEF
) (
	input  logic  clk,
	input  logic  rst,
	simp_if.slave bus_i,
	input  logic  hit_i,
	input  logic  miss_i
);

	logic [CNT_W-1:0]            hit_q, miss_q;
	logic                        hit_sat, miss_sat;
	logic                        done_q;
	logic                        req_new;
	logic                        clr_wr;
	logic [axil_pkg::DATA_W-1:0] rd_word;
	logic [axil_pkg::DATA_W-1:0] rdata_q;

	assign hit_sat  = &hit_q;   // Counter stuck at all ones.
	assign miss_sat = &miss_q;
	assign req_new  = bus_i.valid && !done_q;
	assign clr_wr   = req_new && bus_i.wr && (bus_i.addr == pref_pkg::REG_CLEAR);

	// Clear has priority over a same cycle event.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			hit_q  <= '0;
			miss_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= req_new;
			if (clr_wr && bus_i.wdata[0])
				hit_q <= '0;
			else if (hit_i && !hit_sat)
				hit_q <= hit_q + 1'b1;
			if (clr_wr && bus_i.wdata[1])
				miss_q <= '0;
			else if (miss_i && !miss_sat)
				miss_q <= miss_q + 1'b1;
		end
	end

	// Counts read back zero-extended. Writes to anything but CLEAR are dropped.
	always_comb begin
		rd_word = '0;
		case (bus_i.addr)
			pref_pkg::REG_HITS:   rd_word[CNT_W-1:0] = hit_q;
			pref_pkg::REG_MISSES: rd_word[CNT_W-1:0] = miss_q;
			pref_pkg::REG_STATUS: rd_word[1:0] = {miss_sat, hit_sat};
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req_new)
			rdata_q <= rd_word;
	end

	assign bus_i.done  = done_q;
	assign bus_i.rdata = rdata_q;

endmodule

/* pref_cfg_regs.sv */
// Prefetch configuration registers with byte writes and a decoded control word.
`timescale 1ns/1ns

module pref_cfg_regs (
	input  logic        clk,
	input  logic        rst,
	simp_if.slave       bus_i,
	output logic        pref_enable_o,
	output logic [1:0]  pref_mode_o,
	output logic [3:0]  pref_degree_o,
	output logic [31:0] pref_base_o,
	output logic [31:0] pref_stride_o
);

	pref_pkg::pref_ctrl_u                   ctrl_q;
	logic [axil_pkg::STRB_W-1:0][7:0]       base_q;
	logic [axil_pkg::STRB_W-1:0][7:0]       stride_q;
	logic [axil_pkg::STRB_W-1:0][7:0]       scratch_q;
	logic                                   done_q;
	logic [axil_pkg::DATA_W-1:0]            rdata_q;
	logic                                   req_new;

	// A request is new in its first valid cycle only.
	assign req_new = bus_i.valid && !done_q;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			ctrl_q    <= '0;  // Prefetcher comes up disabled.
			base_q    <= '0;
			stride_q  <= '0;
			scratch_q <= '0;
			done_q    <= 1'b0;
		end else begin
			done_q <= req_new;
			if (req_new && bus_i.wr) begin
				for (int b = 0; b < axil_pkg::STRB_W; b++) begin
					if (bus_i.be[b]) begin
						case (bus_i.addr)
							pref_pkg::REG_CTRL:    ctrl_q.bytes[b] <= bus_i.wdata[8*b +: 8];
							pref_pkg::REG_BASE:    base_q[b]       <= bus_i.wdata[8*b +: 8];
							pref_pkg::REG_STRIDE:  stride_q[b]     <= bus_i.wdata[8*b +: 8];
							pref_pkg::REG_SCRATCH: scratch_q[b]    <= bus_i.wdata[8*b +: 8];
							default: ;
						endcase
					end
				end
			end
		end
	end

	// Read data is captured with the request and presented with done.
	always_ff @(posedge clk) begin
		if (req_new) begin
			case (bus_i.addr)
				pref_pkg::REG_CTRL:    rdata_q <= ctrl_q & pref_pkg::CTRL_MASK;
				pref_pkg::REG_BASE:    rdata_q <= base_q;
				pref_pkg::REG_STRIDE:  rdata_q <= stride_q;
				pref_pkg::REG_SCRATCH: rdata_q <= scratch_q;
				default:               rdata_q <= '0;
			endcase
		end
	end

	assign bus_i.done  = done_q;
	assign bus_i.rdata = rdata_q;

	assign pref_enable_o = ctrl_q.f.enable;
	assign pref_mode_o   = ctrl_q.f.mode;
	assign pref_degree_o = ctrl_q.f.degree;
	assign pref_base_o   = base_q;
	assign pref_stride_o = stride_q;

endmodule

/* simp_addr_router.sv */
// Address router that steers simp transfers to the config bank or the counters.
`timescale 1ns/1ns

module simp_addr_router (
	simp_if.slave  bus_i,
	simp_if.master regs_o,
	simp_if.master cnt_o
);

	logic sel_cnt;

	// Address bit 4 picks the counter half of the map.
	assign sel_cnt = bus_i.addr[4];

	// Request fields go to both slaves. Only the selected one sees valid.
	assign regs_o.addr  = bus_i.addr;
	assign regs_o.wdata = bus_i.wdata;
	assign regs_o.be    = bus_i.be;
	assign regs_o.wr    = bus_i.wr;
	assign regs_o.rd    = bus_i.rd;
	assign regs_o.valid = bus_i.valid && !sel_cnt;

	assign cnt_o.addr   = bus_i.addr;
	assign cnt_o.wdata  = bus_i.wdata;
	assign cnt_o.be     = bus_i.be;
	assign cnt_o.wr     = bus_i.wr;
	assign cnt_o.rd     = bus_i.rd;
	assign cnt_o.valid  = bus_i.valid && sel_cnt;

	// Reply of the selected slave back to the bridge.
	assign bus_i.rdata = sel_cnt ? cnt_o.rdata : regs_o.rdata;
	assign bus_i.done  = sel_cnt ? cnt_o.done : regs_o.done;

endmodule

/* axil_simp_bridge.sv */
// AXI-lite slave that carries out one simp transfer per AXI-lite transaction.
`timescale 1ns/1ns

module axil_simp_bridge (
	input  logic                        clk,
	input  logic                        rst,

	input  logic                        awvalid_i,
	input  logic [axil_pkg::ADDR_W-1:0] awaddr_i,
	input  logic                        wvalid_i,
	input  logic [axil_pkg::DATA_W-1:0] wdata_i,
	input  logic [axil_pkg::STRB_W-1:0] wstrb_i,
	input  logic                        bready_i,
	input  logic                        arvalid_i,
	input  logic [axil_pkg::ADDR_W-1:0] araddr_i,
	input  logic                        rready_i,
	input  logic [2:0]                  awprot_i,  // Accepted, not checked.
	input  logic [2:0]                  arprot_i,  // Accepted, not checked.

	output logic                        awready_o,
	output logic                        wready_o,
	output logic                        bvalid_o,
	output logic [1:0]                  bresp_o,
	output logic                        arready_o,
	output logic                        rvalid_o,
	output logic [axil_pkg::DATA_W-1:0] rdata_o,
	output logic [1:0]                  rresp_o,

	simp_if.master                      bus_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_COLLECT,  // One of AW and W is in, waiting for the other.
		ST_SIMP_WR,
		ST_WR_RESP,
		ST_SIMP_RD,
		ST_RD_RESP
	} state_t;

	state_t state_q, state_d;

	logic ar_hs, aw_hs, w_hs, r_hs, b_hs;
	logic aw_got_q, w_got_q;
	logic aw_in, w_in;

	logic [axil_pkg::ADDR_W-1:0] addr_q;
	logic [axil_pkg::DATA_W-1:0] wdata_q;
	logic [axil_pkg::STRB_W-1:0] be_q;
	logic [axil_pkg::DATA_W-1:0] rdata_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI-lite handshakes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Reads are only taken when idle. A pending read blocks the write channels.
	assign arready_o = (state_q == ST_IDLE);
	assign awready_o = !aw_got_q &&
		((state_q == ST_IDLE && !arvalid_i) || state_q == ST_WR_COLLECT);
	assign wready_o  = !w_got_q &&
		((state_q == ST_IDLE && !arvalid_i) || state_q == ST_WR_COLLECT);

	assign ar_hs = arvalid_i && arready_o;
	assign aw_hs = awvalid_i && awready_o;
	assign w_hs  = wvalid_i && wready_o;
	assign r_hs  = rready_i && rvalid_o;
	assign b_hs  = bready_i && bvalid_o;

	assign aw_in = aw_got_q || aw_hs;  // Address accepted now or before.
	assign w_in  = w_got_q || w_hs;

	assign bvalid_o = (state_q == ST_WR_RESP);
	assign rvalid_o = (state_q == ST_RD_RESP);
	assign rdata_o  = rdata_q;
	assign bresp_o  = axil_pkg::RESP_OKAY;
	assign rresp_o  = axil_pkg::RESP_OKAY;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Transaction FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (ar_hs)
					state_d = ST_SIMP_RD;
				else if (aw_in && w_in)
					state_d = ST_SIMP_WR;
				else if (aw_hs || w_hs)
					state_d = ST_WR_COLLECT;
			end
			ST_WR_COLLECT: if (aw_in && w_in) state_d = ST_SIMP_WR;
			ST_SIMP_WR:    if (bus_o.done) state_d = ST_WR_RESP;
			ST_WR_RESP:    if (b_hs) state_d = ST_IDLE;
			ST_SIMP_RD:    if (bus_o.done) state_d = ST_RD_RESP;
			ST_RD_RESP:    if (r_hs) state_d = ST_IDLE;
			default:       state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			aw_got_q <= 1'b0;
			w_got_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			// Both halves of the write are consumed once the simp write starts.
			if (state_d == ST_SIMP_WR) begin
				aw_got_q <= 1'b0;
				w_got_q  <= 1'b0;
			end else begin
				if (aw_hs)
					aw_got_q <= 1'b1;
				if (w_hs)
					w_got_q <= 1'b1;
			end
		end
	end

	// Request and response payload. The strobes are latched with the data.
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			addr_q <= araddr_i;
			be_q   <= '1;
		end
		if (aw_hs)
			addr_q <= awaddr_i;
		if (w_hs) begin
			wdata_q <= wdata_i;
			be_q    <= wstrb_i;
		end
		if (state_q == ST_SIMP_RD && bus_o.done)
			rdata_q <= bus_o.rdata;
	end

	// Simp request, held steady until done by the registers above.
	assign bus_o.addr  = addr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.be    = be_q;
	assign bus_o.wr    = (state_q == ST_SIMP_WR);
	assign bus_o.rd    = (state_q == ST_SIMP_RD);
	assign bus_o.valid = bus_o.wr || bus_o.rd;

endmodule

/* simp_if.sv */
// Simple request/done bus between the bridge, the router and the slaves.
`timescale 1ns/1ns

interface simp_if;

	logic [axil_pkg::ADDR_W-1:0] addr;
	logic [axil_pkg::DATA_W-1:0] wdata;
	logic [axil_pkg::STRB_W-1:0] be;     // Byte enables, all ones on reads.
	logic                        wr;
	logic                        rd;
	logic                        valid;  // Held with the request until done.
	logic [axil_pkg::DATA_W-1:0] rdata;  // Valid together with done.
	logic                        done;   // One cycle pulse from the slave.

	modport master (
		output addr, wdata, be, wr, rd, valid,
		input  rdata, done
	);

	modport slave (
		input  addr, wdata, be, wr, rd, valid,
		output rdata, done
	);

endinterface

/* pref_pkg.sv */
// Prefetcher register map, control word layout and counter defaults.

package pref_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map. Address bit 4 separates the counters from the config bank.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [axil_pkg::ADDR_W-1:0] REG_CTRL    = 5'h00;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_BASE    = 5'h04;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_STRIDE  = 5'h08;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_SCRATCH = 5'h0C;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_HITS    = 5'h10;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_MISSES  = 5'h14;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_STATUS  = 5'h18;
	localparam logic [axil_pkg::ADDR_W-1:0] REG_CLEAR   = 5'h1C;

	// Control word fields, enable in bit 0.
	typedef struct packed {
		logic [24:0] reserved;
		logic [3:0]  degree;   // Lines fetched ahead of the demand stream.
		logic [1:0]  mode;
		logic        enable;
	} pref_ctrl_t;

	// Byte lanes for strobed writes, fields for the prefetcher outputs.
	typedef union packed {
		logic [axil_pkg::STRB_W-1:0][7:0] bytes;
		pref_ctrl_t                       f;
	} pref_ctrl_u;

	// Only enable, mode and degree read back.
	localparam logic [axil_pkg::DATA_W-1:0] CTRL_MASK = 32'h0000_007F;

	// Default event counter width.
	localparam int CNT_W_DEF = 16;

endpackage

/* axil_pkg.sv */
// AXI-lite port constants for the prefetcher configuration port.

package axil_pkg;

	// Byte address of the port. Eight word registers fill the whole space.
	localparam int ADDR_W = 5;

	// Data bus width and the number of byte lanes.
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Response codes. Only OKAY is ever returned.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_EXOKAY = 2'b01;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage
